// ==== design/core_pkg.sv ====
// core-internal types: instruction addresses, ALU operations and fetch FSM states
package core_pkg;

        typedef logic [31:0] addr_t;

        typedef enum logic [3:0] {
                ALU_NOP,
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_NOR,
                ALU_SLT,
                ALU_SLL,
                ALU_SRL,
                ALU_LUI
        } alu_op_t;

        typedef enum logic [1:0] {
                FS_IDLE,
                FS_REQ,
                FS_RELEASE
        } fetch_state_t;

        localparam addr_t INST_BYTES = 32'd4;

endpackage

// ==== design/decode_stage.sv ====
// decode stage with field split, ALU op mapping, operand forwarding and the ID/EX register
`timescale 1ns/10ps

module decode_stage
(
        input  logic                clk,
        input  logic                arst_n_i,
        input  logic                id_valid_i,
        input  core_pkg::addr_t     id_pc_i,
        input  isa_pkg::word_t      id_inst_i,
        input  isa_pkg::word_t      rdata1_i,
        input  isa_pkg::word_t      rdata2_i,
        input  logic                ex_fwd_wreg_i,
        input  isa_pkg::reg_addr_t  ex_fwd_wd_i,
        input  isa_pkg::word_t      ex_fwd_data_i,
        input  logic                wb_wreg_i,
        input  isa_pkg::reg_addr_t  wb_wd_i,
        input  isa_pkg::word_t      wb_data_i,
        output isa_pkg::reg_addr_t  raddr1_o,
        output isa_pkg::reg_addr_t  raddr2_o,
        output logic                ex_valid_o,
        output core_pkg::addr_t     ex_pc_o,
        output core_pkg::alu_op_t   ex_alu_op_o,
        output isa_pkg::word_t      ex_src_a_o,
        output isa_pkg::word_t      ex_src_b_o,
        output isa_pkg::reg_addr_t  ex_wd_o,
        output logic                ex_wreg_o
);

        isa_pkg::opcode_t   opcode;
        isa_pkg::funct_t    funct;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::reg_addr_t rd;
        isa_pkg::shamt_t    shamt;
        isa_pkg::imm_t      imm;
        core_pkg::alu_op_t  alu_op;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     imm_ext;
        isa_pkg::word_t     src_a;
        isa_pkg::word_t     src_b;
        logic               use_imm;
        logic               use_shamt;
        logic               sign_ext;
        logic               wreg;

        assign opcode = id_inst_i[31:26];
        assign rs     = id_inst_i[25:21];
        assign rt     = id_inst_i[20:16];
        assign rd     = id_inst_i[15:11];
        assign shamt  = id_inst_i[10:6];
        assign funct  = id_inst_i[5:0];
        assign imm    = id_inst_i[15:0];

        assign raddr1_o = rs;
        assign raddr2_o = rt;

        // the execute result wins over writeback and writeback over the register file
        function automatic isa_pkg::word_t fwd(input isa_pkg::reg_addr_t addr,
                                               input isa_pkg::word_t rf_data);
                if (addr == '0)
                        return '0;
                else if (ex_fwd_wreg_i && (ex_fwd_wd_i == addr))
                        return ex_fwd_data_i;
                else if (wb_wreg_i && (wb_wd_i == addr))
                        return wb_data_i;
                else
                        return rf_data;
        endfunction

        always_comb
        begin
                alu_op    = core_pkg::ALU_NOP;
                use_imm   = 1'b1;
                use_shamt = 1'b0;
                sign_ext  = 1'b0;
                dest      = rt;
                case (opcode)
                isa_pkg::OP_SPECIAL:
                begin
                        use_imm = 1'b0;
                        dest    = rd;
                        case (funct)
                        isa_pkg::FN_ADDU: alu_op = core_pkg::ALU_ADD;
                        isa_pkg::FN_SUBU: alu_op = core_pkg::ALU_SUB;
                        isa_pkg::FN_AND:  alu_op = core_pkg::ALU_AND;
                        isa_pkg::FN_OR:   alu_op = core_pkg::ALU_OR;
                        isa_pkg::FN_XOR:  alu_op = core_pkg::ALU_XOR;
                        isa_pkg::FN_NOR:  alu_op = core_pkg::ALU_NOR;
                        isa_pkg::FN_SLT:  alu_op = core_pkg::ALU_SLT;
                        isa_pkg::FN_SLL:
                        begin
                                alu_op    = core_pkg::ALU_SLL;
                                use_shamt = 1'b1;
                        end
                        isa_pkg::FN_SRL:
                        begin
                                alu_op    = core_pkg::ALU_SRL;
                                use_shamt = 1'b1;
                        end
                        default:          alu_op = core_pkg::ALU_NOP;
                        endcase
                end
                isa_pkg::OP_ADDIU:
                begin
                        alu_op   = core_pkg::ALU_ADD;
                        sign_ext = 1'b1;
                end
                isa_pkg::OP_ANDI: alu_op = core_pkg::ALU_AND;
                isa_pkg::OP_ORI:  alu_op = core_pkg::ALU_OR;
                isa_pkg::OP_XORI: alu_op = core_pkg::ALU_XOR;
                isa_pkg::OP_LUI:  alu_op = core_pkg::ALU_LUI;
                default:          alu_op = core_pkg::ALU_NOP;
                endcase
        end

        assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};

        // shift amount rides on source A
        always_comb
        begin
                src_a = use_shamt ? {27'b0, shamt} : fwd(rs, rdata1_i);
                src_b = use_imm ? imm_ext : fwd(rt, rdata2_i);
        end

        assign wreg = id_valid_i && (alu_op != core_pkg::ALU_NOP) && (dest != '0);

        always_ff @(posedge clk or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        ex_valid_o  <= 1'b0;
                        ex_wreg_o   <= 1'b0;
                        ex_alu_op_o <= core_pkg::ALU_NOP;
                end
                else
                begin
                        ex_valid_o  <= id_valid_i;
                        ex_wreg_o   <= wreg;
                        ex_alu_op_o <= alu_op;
                end
        end

        always_ff @(posedge clk)
        begin
                ex_pc_o    <= id_pc_i;
                ex_src_a_o <= src_a;
                ex_src_b_o <= src_b;
                ex_wd_o    <= dest;
        end

endmodule

// ==== design/execute_stage.sv ====
// execute stage: ALU, forwarding result back to decode and the EX/WB register
`timescale 1ns/10ps

module execute_stage
(
        input  logic                clk,
        input  logic                arst_n_i,
        input  logic                ex_valid_i,
        input  core_pkg::addr_t     ex_pc_i,
        input  core_pkg::alu_op_t   ex_alu_op_i,
        input  isa_pkg::word_t      ex_src_a_i,
        input  isa_pkg::word_t      ex_src_b_i,
        input  isa_pkg::reg_addr_t  ex_wd_i,
        input  logic                ex_wreg_i,
        output logic                fwd_wreg_o,
        output isa_pkg::reg_addr_t  fwd_wd_o,
        output isa_pkg::word_t      fwd_data_o,
        output logic                wb_wreg_o,
        output isa_pkg::reg_addr_t  wb_wd_o,
        output isa_pkg::word_t      wb_data_o,
        output core_pkg::addr_t     wb_pc_o
);

        isa_pkg::word_t result;

        always_comb
        begin
                case (ex_alu_op_i)
                core_pkg::ALU_ADD: result = ex_src_a_i + ex_src_b_i;
                core_pkg::ALU_SUB: result = ex_src_a_i - ex_src_b_i;
                core_pkg::ALU_AND: result = ex_src_a_i & ex_src_b_i;
                core_pkg::ALU_OR:  result = ex_src_a_i | ex_src_b_i;
                core_pkg::ALU_XOR: result = ex_src_a_i ^ ex_src_b_i;
                core_pkg::ALU_NOR: result = ~(ex_src_a_i | ex_src_b_i);
                core_pkg::ALU_SLT: result = {31'b0, $signed(ex_src_a_i) < $signed(ex_src_b_i)};
                // shifts move rt by the amount in A
                core_pkg::ALU_SLL: result = ex_src_b_i << ex_src_a_i[4:0];
                core_pkg::ALU_SRL: result = ex_src_b_i >> ex_src_a_i[4:0];
                core_pkg::ALU_LUI: result = {ex_src_b_i[15:0], 16'b0};
                default:           result = '0;
                endcase
        end

        assign fwd_wreg_o = ex_valid_i && ex_wreg_i;
        assign fwd_wd_o   = ex_wd_i;
        assign fwd_data_o = result;

        always_ff @(posedge clk or negedge arst_n_i)
        begin
                if (!arst_n_i)
                        wb_wreg_o <= 1'b0;
                else
                        wb_wreg_o <= fwd_wreg_o;
        end

        always_ff @(posedge clk)
        begin
                wb_wd_o   <= ex_wd_i;
                wb_data_o <= result;
                wb_pc_o   <= ex_pc_i;
        end

endmodule

// ==== design/fetch_unit.sv ====
// fetch stage: pc, four-phase req/ack instruction fetch and the IF/ID register
`timescale 1ns/10ps

module fetch_unit
#(
        parameter core_pkg::addr_t RESET_PC = 32'h0000_0000
)
(
        input  logic               clk,
        input  logic               arst_n_i,
        input  logic               imem_ack_i,
        input  isa_pkg::word_t     imem_data_i,
        output logic               imem_req_o,
        output core_pkg::addr_t    imem_addr_o,
        output logic               id_valid_o,
        output core_pkg::addr_t    id_pc_o,
        output isa_pkg::word_t     id_inst_o
);

        core_pkg::fetch_state_t state;
        core_pkg::addr_t        pc;
        logic                   take;

        // instruction accepted on this edge
        assign take = (state == core_pkg::FS_REQ) && imem_ack_i;

        assign imem_req_o  = (state == core_pkg::FS_REQ);
        assign imem_addr_o = pc;

        always_ff @(posedge clk or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        state      <= core_pkg::FS_IDLE;
                        pc         <= RESET_PC;
                        id_valid_o <= 1'b0;
                end
                else
                begin
                        id_valid_o <= take;
                        case (state)
                        core_pkg::FS_IDLE:
                        begin
                                state <= core_pkg::FS_REQ;
                        end
                        core_pkg::FS_REQ:
                        begin
                                if (imem_ack_i)
                                begin
                                        state <= core_pkg::FS_RELEASE;
                                        pc    <= pc + core_pkg::INST_BYTES;
                                end
                        end
                        core_pkg::FS_RELEASE:
                        begin
                                // wait for ack to drop before the next request
                                if (!imem_ack_i)
                                        state <= core_pkg::FS_REQ;
                        end
                        default:
                        begin
                                state <= core_pkg::FS_IDLE;
                        end
                        endcase
                end
        end

        // IF/ID payload
        always_ff @(posedge clk)
        begin
                if (take)
                begin
                        id_pc_o   <= pc;
                        id_inst_o <= imem_data_i;
                end
        end

endmodule

// ==== design/isa_pkg.sv ====
// MIPS32 instruction fields, types and opcode/funct values used by decode and the top level
package isa_pkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_addr_t;
        typedef logic [5:0]  opcode_t;
        typedef logic [5:0]  funct_t;
        typedef logic [4:0]  shamt_t;
        typedef logic [15:0] imm_t;

        // primary opcodes
        localparam opcode_t OP_SPECIAL = 6'b000000;
        localparam opcode_t OP_ADDIU   = 6'b001001;
        localparam opcode_t OP_ANDI    = 6'b001100;
        localparam opcode_t OP_ORI     = 6'b001101;
        localparam opcode_t OP_XORI    = 6'b001110;
        localparam opcode_t OP_LUI     = 6'b001111;

        // SPECIAL function codes
        localparam funct_t FN_SLL  = 6'b000000;
        localparam funct_t FN_SRL  = 6'b000010;
        localparam funct_t FN_ADDU = 6'b100001;
        localparam funct_t FN_SUBU = 6'b100011;
        localparam funct_t FN_AND  = 6'b100100;
        localparam funct_t FN_OR   = 6'b100101;
        localparam funct_t FN_XOR  = 6'b100110;
        localparam funct_t FN_NOR  = 6'b100111;
        localparam funct_t FN_SLT  = 6'b101010;

endpackage

// ==== design/mini_mips.sv ====
// top level of the four-stage MIPS32 ALU core, wires fetch, decode, execute and regfile
`timescale 1ns/10ps

module mini_mips
#(
        parameter core_pkg::addr_t RESET_PC = 32'hbfc00000
)
(
        input  logic                clk,
        input  logic                arst_n_i,
        input  logic                imem_ack_i,
        input  isa_pkg::word_t      imem_data_i,
        output logic                imem_req_o,
        output core_pkg::addr_t     imem_addr_o,
        output logic                dbg_wb_wen_o,
        output isa_pkg::reg_addr_t  dbg_wb_num_o,
        output isa_pkg::word_t      dbg_wb_data_o,
        output core_pkg::addr_t     dbg_wb_pc_o
);

        // IF/ID
        logic               id_valid;
        core_pkg::addr_t    id_pc;
        isa_pkg::word_t     id_inst;

        // decode <-> register file
        isa_pkg::reg_addr_t raddr1;
        isa_pkg::reg_addr_t raddr2;
        isa_pkg::word_t     rdata1;
        isa_pkg::word_t     rdata2;

        // ID/EX
        logic               ex_valid;
        core_pkg::addr_t    ex_pc;
        core_pkg::alu_op_t  ex_alu_op;
        isa_pkg::word_t     ex_src_a;
        isa_pkg::word_t     ex_src_b;
        isa_pkg::reg_addr_t ex_wd;
        logic               ex_wreg;

        // execute result fed back to decode
        logic               ex_fwd_wreg;
        isa_pkg::reg_addr_t ex_fwd_wd;
        isa_pkg::word_t     ex_fwd_data;

        // EX/WB
        logic               wb_wreg;
        isa_pkg::reg_addr_t wb_wd;
        isa_pkg::word_t     wb_data;
        core_pkg::addr_t    wb_pc;

        assign dbg_wb_wen_o  = wb_wreg;
        assign dbg_wb_num_o  = wb_wd;
        assign dbg_wb_data_o = wb_data;
        assign dbg_wb_pc_o   = wb_pc;

        fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
                .clk(clk), .arst_n_i(arst_n_i),
                .imem_ack_i(imem_ack_i), .imem_data_i(imem_data_i),
                .imem_req_o(imem_req_o), .imem_addr_o(imem_addr_o),
                .id_valid_o(id_valid), .id_pc_o(id_pc), .id_inst_o(id_inst)
        );

        regfile u_regfile (
                .clk(clk), .arst_n_i(arst_n_i),
                .we_i(wb_wreg), .waddr_i(wb_wd), .wdata_i(wb_data),
                .raddr1_i(raddr1), .raddr2_i(raddr2),
                .rdata1_o(rdata1), .rdata2_o(rdata2)
        );

        decode_stage u_decode (
                .clk(clk), .arst_n_i(arst_n_i),
                .id_valid_i(id_valid), .id_pc_i(id_pc), .id_inst_i(id_inst),
                .rdata1_i(rdata1), .rdata2_i(rdata2),
                .ex_fwd_wreg_i(ex_fwd_wreg), .ex_fwd_wd_i(ex_fwd_wd),
                .ex_fwd_data_i(ex_fwd_data),
                .wb_wreg_i(wb_wreg), .wb_wd_i(wb_wd), .wb_data_i(wb_data),
                .raddr1_o(raddr1), .raddr2_o(raddr2),
                .ex_valid_o(ex_valid), .ex_pc_o(ex_pc), .ex_alu_op_o(ex_alu_op),
                .ex_src_a_o(ex_src_a), .ex_src_b_o(ex_src_b),
                .ex_wd_o(ex_wd), .ex_wreg_o(ex_wreg)
        );

        execute_stage u_execute (
                .clk(clk), .arst_n_i(arst_n_i),
                .ex_valid_i(ex_valid), .ex_pc_i(ex_pc), .ex_alu_op_i(ex_alu_op),
                .ex_src_a_i(ex_src_a), .ex_src_b_i(ex_src_b),
                .ex_wd_i(ex_wd), .ex_wreg_i(ex_wreg),
                .fwd_wreg_o(ex_fwd_wreg), .fwd_wd_o(ex_fwd_wd), .fwd_data_o(ex_fwd_data),
                .wb_wreg_o(wb_wreg), .wb_wd_o(wb_wd), .wb_data_o(wb_data), .wb_pc_o(wb_pc)
        );

endmodule

// ==== design/regfile.sv ====
// 32 x 32 general register file with two combinational read ports and one write port
`timescale 1ns/10ps

module regfile
(
        input  logic               clk,
        input  logic               arst_n_i,
        input  logic               we_i,
        input  isa_pkg::reg_addr_t waddr_i,
        input  isa_pkg::word_t     wdata_i,
        input  isa_pkg::reg_addr_t raddr1_i,
        input  isa_pkg::reg_addr_t raddr2_i,
        output isa_pkg::word_t     rdata1_o,
        output isa_pkg::word_t     rdata2_o
);

        isa_pkg::word_t regs [32];

        // r0 reads zero and a same-cycle write passes straight through
        function automatic isa_pkg::word_t read_port(input isa_pkg::reg_addr_t addr);
                if (addr == '0)
                        return '0;
                else if (we_i && (waddr_i == addr))
                        return wdata_i;
                else
                        return regs[addr];
        endfunction

        always_comb
        begin
                rdata1_o = read_port(raddr1_i);
                rdata2_o = read_port(raddr2_i);
        end

        always_ff @(posedge clk or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        for (int i = 0; i < 32; i++)
                                regs[i] <= '0;
                end
                else if (we_i && (waddr_i != '0))
                begin
                        regs[waddr_i] <= wdata_i;
                end
        end

endmodule

// ==== project.f ====
design/isa_pkg.sv
design/core_pkg.sv
design/fetch_unit.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/mini_mips.sv
sim/mini_mips_asserts.sv
sim/tb_mini_mips.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; exits non-zero unless it passes
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mini_mips \
        -f project.f --Mdir obj_dir -o tb_mini_mips
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

out=$(./obj_dir/tb_mini_mips)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
        exit 0
fi
exit 1

// ==== sim/mini_mips_asserts.sv ====
// concurrent checks on the fetch handshake and writeback port, bound into mini_mips
`timescale 1ns/10ps

module mini_mips_asserts
(
        input logic               clk,
        input logic               arst_n_i,
        input logic               req_i,
        input logic               ack_i,
        input core_pkg::addr_t    addr_i,
        input logic               wb_wen_i,
        input isa_pkg::reg_addr_t wb_num_i
);

        // req holds until ack arrives
        req_until_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
                (req_i && !ack_i) |=> req_i)
                else $error("fetch request dropped before ack");

        addr_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
                (req_i && !ack_i) |=> $stable(addr_i))
                else $error("fetch address changed while the request was pending");

        // no new request until ack is low again
        no_req_while_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
                (!req_i && ack_i) |=> !req_i)
                else $error("fetch request raised while ack was still high");

        no_r0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
                wb_wen_i |-> (wb_num_i != '0))
                else $error("writeback to register 0");

endmodule

bind mini_mips mini_mips_asserts u_asserts (
        .clk(clk),
        .arst_n_i(arst_n_i),
        .req_i(imem_req_o),
        .ack_i(imem_ack_i),
        .addr_i(imem_addr_o),
        .wb_wen_i(dbg_wb_wen_o),
        .wb_num_i(dbg_wb_num_o)
);

// ==== sim/program_trace.txt ====
# I <word index from the reset pc> <instruction>, hex; other addresses read as a no-op
# W <pc> <register> <data>, hex, the expected writebacks in program order
I 00 3c011234 # lui   r1, 0x1234
I 01 34215678 # ori   r1, r1, 0x5678
I 02 2402ffff # addiu r2, r0, -1
I 03 24238000 # addiu r3, r1, -0x8000
I 04 30448001 # andi  r4, r2, 0x8001
I 05 3825ffff # xori  r5, r1, 0xffff
I 06 00233021 # addu  r6, r1, r3
I 07 00613823 # subu  r7, r3, r1
I 08 00c24024 # and   r8, r6, r2
I 09 00244825 # or    r9, r1, r4
I 0a 01275026 # xor   r10, r9, r7
I 0b 00005827 # nor   r11, r0, r0
I 0c 00e1602a # slt   r12, r7, r1
I 0d 0027682a # slt   r13, r1, r7
I 0e 00017100 # sll   r14, r1, 4
I 0f 000e7a02 # srl   r15, r14, 8
I 10 24200005 # addiu r0, r1, 5
I 11 8c220000 # lw    r2, 0(r1), not supported
I 12 00028021 # addu  r16, r0, r2
I 13 26110002 # addiu r17, r16, 2
I 14 02309021 # addu  r18, r17, r16
I 15 02329823 # subu  r19, r17, r18
W bfc00000 01 12340000
W bfc00004 01 12345678
W bfc00008 02 ffffffff
W bfc0000c 03 1233d678
W bfc00010 04 00008001
W bfc00014 05 1234a987
W bfc00018 06 24682cf0
W bfc0001c 07 ffff8000
W bfc00020 08 24682cf0
W bfc00024 09 1234d679
W bfc00028 0a edcb5679
W bfc0002c 0b ffffffff
W bfc00030 0c 00000001
W bfc00034 0d 00000000
W bfc00038 0e 23456780
W bfc0003c 0f 00234567
W bfc00048 10 ffffffff
W bfc0004c 11 00000001
W bfc00050 12 00000000
W bfc00054 13 00000001

// ==== sim/tb_mini_mips.sv ====
// testbench for mini_mips that plays the instruction memory from a trace and checks writebacks
`timescale 1ns/10ps

module tb_mini_mips;

        localparam core_pkg::addr_t RESET_PC     = 32'hbfc00000;
        localparam string           TRACE_FILE   = "sim/program_trace.txt";
        localparam int              DRAIN_CYCLES = 16;

        logic               clk = 1'b0;
        logic               arst_n_i = 1'b0;
        logic               imem_ack_i = 1'b0;
        isa_pkg::word_t     imem_data_i = '0;
        logic               imem_req_o;
        core_pkg::addr_t    imem_addr_o;
        logic               dbg_wb_wen_o;
        isa_pkg::reg_addr_t dbg_wb_num_o;
        isa_pkg::word_t     dbg_wb_data_o;
        core_pkg::addr_t    dbg_wb_pc_o;

        // program image keyed by word index from the reset pc
        isa_pkg::word_t     imem [int];
        core_pkg::addr_t    exp_pc_q [$];
        isa_pkg::reg_addr_t exp_num_q [$];
        isa_pkg::word_t     exp_data_q [$];

        int   seed = 32'h63e8859a;
        int   delay_cycles;
        int   wait_left;
        logic waiting;
        int   cycles;
        int   limit;
        logic fetch_seen;
        logic ack_seen;

        mini_mips #(.RESET_PC(RESET_PC)) dut_i (
                .clk(clk),
                .arst_n_i(arst_n_i),
                .imem_ack_i(imem_ack_i),
                .imem_data_i(imem_data_i),
                .imem_req_o(imem_req_o),
                .imem_addr_o(imem_addr_o),
                .dbg_wb_wen_o(dbg_wb_wen_o),
                .dbg_wb_num_o(dbg_wb_num_o),
                .dbg_wb_data_o(dbg_wb_data_o),
                .dbg_wb_pc_o(dbg_wb_pc_o)
        );

        always #4 clk = ~clk;

        task automatic stop_run();
                $display("Something failed");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic check_pc(input string what, input core_pkg::addr_t got,
                                input core_pkg::addr_t exp);
                if (got !== exp)
                begin
                        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_num(input string what, input isa_pkg::reg_addr_t got,
                                 input isa_pkg::reg_addr_t exp);
                if (got !== exp)
                begin
                        $display("Mismatch at %0t: %s is r%0d, expected r%0d",
                                 $time, what, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_data(input string what, input isa_pkg::word_t got,
                                  input isa_pkg::word_t exp);
                if (got !== exp)
                begin
                        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
                        stop_run();
                end
        endtask

        task automatic load_trace();
                int          fd;
                int          fields;
                logic        bad;
                string       line;
                string       body;
                logic [31:0] col_a;
                logic [31:0] col_b;
                logic [31:0] col_c;
                fd = $fopen(TRACE_FILE, "r");
                if (fd == 0)
                begin
                        $display("could not open the trace file %s", TRACE_FILE);
                        stop_run();
                end
                while ($fgets(line, fd) != 0)
                begin
                        if (line.len() < 2 || line[0] == "#")
                                continue;
                        bad  = 1'b0;
                        body = line.substr(1, line.len() - 1);
                        if (line[0] == "I")
                        begin
                                fields = $sscanf(body, "%h %h", col_a, col_b);
                                if (fields != 2)
                                        bad = 1'b1;
                                else
                                        imem[int'(col_a)] = col_b;
                        end
                        else if (line[0] == "W")
                        begin
                                fields = $sscanf(body, "%h %h %h", col_a, col_b, col_c);
                                if (fields != 3)
                                        bad = 1'b1;
                                exp_pc_q.push_back(col_a);
                                exp_num_q.push_back(col_b[4:0]);
                                exp_data_q.push_back(col_c);
                        end
                        else
                                bad = 1'b1;
                        if (bad)
                        begin
                                $display("malformed line in the trace file: %s", line);
                                stop_run();
                        end
                end
                $fclose(fd);
                if (imem.num() == 0 || exp_pc_q.size() == 0)
                begin
                        $display("the trace file holds no program or no expected writebacks");
                        stop_run();
                end
        endtask

        // anything outside the program reads as sll r0, r0, 0
        function automatic isa_pkg::word_t fetch_word(input core_pkg::addr_t addr);
                int idx;
                idx = int'((addr - RESET_PC) >> 2);
                if (imem.exists(idx))
                        return imem[idx];
                else
                        return '0;
        endfunction

        // instruction memory that acks after 0 to 3 idle cycles
        always @(posedge clk)
        begin
                if (!arst_n_i)
                begin
                        imem_ack_i <= 1'b0;
                        waiting    <= 1'b0;
                end
                else if (imem_ack_i)
                begin
                        // data held until the core lets go of req
                        if (!imem_req_o)
                                imem_ack_i <= 1'b0;
                end
                else if (imem_req_o)
                begin
                        if (waiting)
                                delay_cycles = wait_left;
                        else
                                delay_cycles = $unsigned($random(seed)) % 4;
                        if (delay_cycles == 0)
                        begin
                                imem_ack_i  <= 1'b1;
                                imem_data_i <= fetch_word(imem_addr_o);
                                waiting     <= 1'b0;
                        end
                        else
                        begin
                                waiting   <= 1'b1;
                                wait_left <= delay_cycles - 1;
                        end
                end
        end

        initial
        begin
                load_trace();
                limit      = imem.num() * 8 + 50;
                cycles     = 0;
                fetch_seen = 1'b0;
                ack_seen   = 1'b0;
                repeat (4) @(posedge clk);
                if (imem_req_o || dbg_wb_wen_o)
                begin
                        $display("the core is fetching or writing back while in reset");
                        stop_run();
                end
                arst_n_i <= 1'b1;
                while (exp_pc_q.size() != 0)
                begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > limit)
                        begin
                                $display("Timeout: writebacks stopped, %0d still expected",
                                         exp_pc_q.size());
                                $display("gave up after %0d cycles", cycles);
                                stop_run();
                        end
                        if (!fetch_seen && imem_req_o)
                        begin
                                fetch_seen = 1'b1;
                                check_pc("first fetch address", imem_addr_o, RESET_PC);
                        end
                        if (dbg_wb_wen_o)
                        begin
                                if (!ack_seen)
                                begin
                                        $display("a writeback came before any instruction was fetched");
                                        stop_run();
                                end
                                check_pc("writeback pc", dbg_wb_pc_o, exp_pc_q[0]);
                                check_num("writeback register", dbg_wb_num_o, exp_num_q[0]);
                                check_data("writeback data", dbg_wb_data_o, exp_data_q[0]);
                                void'(exp_pc_q.pop_front());
                                void'(exp_num_q.pop_front());
                                void'(exp_data_q.pop_front());
                        end
                        if (imem_ack_i)
                                ack_seen = 1'b1;
                end
                // only no-ops remain past the program
                repeat (DRAIN_CYCLES)
                begin
                        @(posedge clk);
                        if (dbg_wb_wen_o)
                        begin
                                $display("unexpected extra writeback to r%0d from pc %h",
                                         dbg_wb_num_o, dbg_wb_pc_o);
                                stop_run();
                        end
                end
                $display("Everything OK");
                $finish;
        end

endmodule
